//--- verification/xadcStimulus.txt
// header words: sweep count, tempHigh code, tempLow code (12 bit codes, hex)
// then one line per sweep: TEMP VCCINT VCCAUX FLAG as raw 16 bit DRP words
0005
0A00
0900

// sweep 0, temp code 0x850 below tempLow, alarm stays off
8503 5563 9990 0000
// sweep 1, temp code 0xA41 above tempHigh, alarm sets
A412 5571 9987 0000
// sweep 2, temp code 0x950 between thresholds, XADC overTemp flag set
9505 5582 99A1 0009
// sweep 3, temp code 0x880 below tempLow, alarm clears
8807 5554 9973 0000
// sweep 4, temp code 0x960 between thresholds, alarm stays off
9604 5596 9992 0002

//--- flist.f
src/xadcMonPkg.sv
src/drpSequencer.sv
src/tempThreshold.sv
src/monitorRegs.sv
src/xadcMonitorTop.sv
verification/xadcMonitorTb.sv

//--- Makefile
# Verilator lint, build and run of the XADC monitor testbench
VERILATOR ?= verilator
TOP       ?= xadcMonitorTb
FLIST     ?= flist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_PAT  ?= \*\*\* FAILED \*\*\*

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJDIR)

sim: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_PAT)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "PASSED" $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- verification/xadcMonitorTb.sv
/*
 * testbench for the XADC monitor: clock and reset, Wishbone driver,
 * XADC DRP model fed from the stimulus file, checks and timeout
 */
`timescale 1ns/1ns
`default_nettype none

module xadcMonitorTb;

	localparam logic [15:0] defaultPeriod = 16'd40;
	localparam logic [15:0] pollPeriod    = 16'd60;
	// longest DRP answer the model gives
	localparam int maxLatency = 8;
	localparam int busBudget  = 400;

	logic               oscSysClk = 1'b0;
	logic               rstN;
	xadcMonPkg::wbReqT  wbReq;
	xadcMonPkg::wbRspT  wbRsp;
	xadcMonPkg::drpReqT drpReq;
	xadcMonPkg::drpRspT drpRsp = '0;
	logic [1:0]         led;

	// word 0 sweep count, 1 tempHigh, 2 tempLow, then four words per sweep
	logic [15:0] stim [0:63];
	int          nSweeps;
	logic [11:0] tempHigh;
	logic [11:0] tempLow;
	int          cycleCount = 0;
	int          cycleLimit = 2147483647;
	int          curTest = 0;
	int          testErr [1:6];

	// DRP model state
	logic [31:0] randState = 32'd77703;
	int          denCount = 0;
	int          wordIdx = 0;
	int          remain = 0;
	int          drpErr = 0;
	logic [15:0] nextWord = 16'h0000;

	xadcMonitorTop #(
		.defaultPeriod (defaultPeriod)
	) dut (
		.oscSysClk (oscSysClk),
		.rstN      (rstN),
		.wbReq     (wbReq),
		.wbRsp     (wbRsp),
		.drpReq    (drpReq),
		.drpRsp    (drpRsp),
		.led       (led)
	);

	always #10 oscSysClk = ~oscSysClk;

	// ------------------------------
	// helpers
	// ------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// XADC register order within one sweep
	function automatic logic [6:0] sweepAddr(input int n);
		case (n % 4)
			0: sweepAddr = 7'h00;
			1: sweepAddr = 7'h01;
			2: sweepAddr = 7'h02;
			default: sweepAddr = 7'h3F;
		endcase
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[ERROR] %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, got);
		testErr[curTest] = testErr[curTest] + 1;
	endtask

	task automatic reportFailure(input string what);
		$display("test %0d: %s", curTest, what);
		testErr[curTest] = testErr[curTest] + 1;
	endtask

	task automatic finishTest(input int t, input string title);
		if (testErr[t] == 0) begin
			$display("test %0d %s: ok", t, title);
		end else begin
			$display("test %0d %s: %0d errors", t, title, testErr[t]);
		end
	endtask

	// one Wishbone classic cycle, ack is expected on the next clock
	task automatic busAccess(input logic we, input logic [3:0] adr, input logic [31:0] datW,
		output logic [31:0] datR);
		int waited;
		waited = 0;
		@(negedge oscSysClk);
		wbReq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, datW: datW};
		@(negedge oscSysClk);
		while (!wbRsp.ack && waited < 8) begin
			waited = waited + 1;
			@(negedge oscSysClk);
		end
		datR = wbRsp.datR;
		if (!wbRsp.ack) begin
			reportFailure($sformatf("access to register %0d never got an ack", adr));
		end else if (waited != 0) begin
			reportFailure($sformatf("ack for register %0d came %0d cycles late", adr, waited));
		end
		wbReq = '0;
		@(negedge oscSysClk);
		if (wbRsp.ack) begin
			reportFailure($sformatf("ack for register %0d lasted more than one cycle", adr));
		end
	endtask

	task automatic busRead(input logic [3:0] adr, output logic [31:0] dat);
		busAccess(1'b0, adr, 32'h0000_0000, dat);
	endtask

	task automatic busWrite(input logic [3:0] adr, input logic [31:0] dat);
		logic [31:0] unusedRd;
		busAccess(1'b1, adr, dat, unusedRd);
	endtask

	// ------------------------------
	// XADC DRP model
	// ------------------------------
	// answers each den after 1 to 8 cycles with the next file word
	always @(negedge oscSysClk) begin
		drpRsp <= '0;
		if (remain > 0) begin
			remain = remain - 1;
			if (remain == 0) begin
				drpRsp <= '{drdy: 1'b1, dout: nextWord};
			end
		end
		if (drpReq.den) begin
			if (drpReq.daddr !== sweepAddr(denCount)) begin
				$display("[ERROR] %0t ns: drpReq.daddr expected 0x%h, got 0x%h",
					$time, sweepAddr(denCount), drpReq.daddr);
				drpErr = drpErr + 1;
			end
			// reads only, the XADC stays in its default sequence
			if (drpReq.dwe !== 1'b0) begin
				$display("[ERROR] %0t ns: drpReq.dwe expected 0x0, got 0x%h",
					$time, drpReq.dwe);
				drpErr = drpErr + 1;
			end
			if (remain != 0) begin
				$display("DRP model: den arrived while a read was still outstanding");
				drpErr = drpErr + 1;
			end
			randState = xorshift(randState);
			remain = int'(randState % maxLatency) + 1;
			nextWord = (wordIdx < 4 * nSweeps) ? stim[3 + wordIdx] : 16'h0000;
			wordIdx = wordIdx + 1;
			denCount = denCount + 1;
		end
	end

	always @(posedge oscSysClk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		logic [31:0] rd;
		logic [3:0]  adr;
		logic [15:0] word;
		logic        ledPrev;
		logic        expAlarm;
		logic        expSticky0;
		logic        expSticky1;
		logic        cleared;
		int          drpSnap;
		int          denSnap;
		int          errTotal;
		int          failed;
		wbReq = '0;
		rstN = 1'b0;
		for (int t = 1; t <= 6; t++) testErr[t] = 0;
		$readmemh("verification/xadcStimulus.txt", stim);
		nSweeps = int'(stim[0]);
		tempHigh = stim[1][11:0];
		tempLow = stim[2][11:0];
		cycleLimit = (nSweeps + 2) * (4 * maxLatency + int'(pollPeriod) + 4) + busBudget;
		repeat (3) @(negedge oscSysClk);
		rstN = 1'b1;

		// reset values
		curTest = 1;
		if (drpReq.den !== 1'b0) reportMismatch("drpReq.den", {31'h0, drpReq.den}, 32'h0);
		if (led !== 2'b00) reportMismatch("led", {30'h0, led}, 32'h0);
		busRead(xadcMonPkg::REG_CTRL, rd);
		if (rd !== {defaultPeriod, 16'h0000}) begin
			reportMismatch("REG_CTRL", rd, {defaultPeriod, 16'h0000});
		end
		busRead(xadcMonPkg::REG_THRESH, rd);
		if (rd !== 32'h0FFF_0000) reportMismatch("REG_THRESH", rd, 32'h0FFF_0000);
		for (int a = 2; a < 8; a++) begin
			adr = 4'(a);
			busRead(adr, rd);
			if (rd !== 32'h0) reportMismatch($sformatf("register %0d", a), rd, 32'h0);
		end
		if (denCount != 0) reportFailure("den rose while enable was still 0");
		finishTest(1, "reset values");

		// readback and read-only words
		curTest = 2;
		busWrite(xadcMonPkg::REG_CTRL, 32'h0123_0000);
		busRead(xadcMonPkg::REG_CTRL, rd);
		if (rd !== 32'h0123_0000) reportMismatch("REG_CTRL", rd, 32'h0123_0000);
		busWrite(xadcMonPkg::REG_THRESH, 32'h0ABC_0123);
		busRead(xadcMonPkg::REG_THRESH, rd);
		if (rd !== 32'h0ABC_0123) reportMismatch("REG_THRESH", rd, 32'h0ABC_0123);
		busWrite(xadcMonPkg::REG_TEMP, 32'h0000_BEEF);
		busRead(xadcMonPkg::REG_TEMP, rd);
		if (rd !== 32'h0) reportMismatch("REG_TEMP", rd, 32'h0);
		finishTest(2, "register access");

		// sweeps, hysteresis and sticky status run together
		busWrite(xadcMonPkg::REG_THRESH, {4'h0, tempHigh, 4'h0, tempLow});
		expAlarm = 1'b0;
		expSticky0 = 1'b0;
		expSticky1 = 1'b0;
		cleared = 1'b0;
		ledPrev = led[1];
		busWrite(xadcMonPkg::REG_CTRL, {pollPeriod, 16'h0001});
		for (int s = 0; s < nSweeps; s++) begin
			// led bit 1 toggles once per finished sweep
			while (led[1] == ledPrev) @(negedge oscSysClk);
			ledPrev = led[1];
			word = stim[3 + 4 * s];
			if (word[15:4] > tempHigh) begin
				if (!expAlarm) expSticky0 = 1'b1;
				expAlarm = 1'b1;
			end else if (word[15:4] < tempLow) begin
				expAlarm = 1'b0;
			end
			word = stim[6 + 4 * s];
			if (word[3]) expSticky1 = 1'b1;
			curTest = 3;
			for (int w = 0; w < 4; w++) begin
				adr = 4'(3 + w);
				busRead(adr, rd);
				if (rd !== {16'h0000, stim[3 + 4 * s + w]}) begin
					reportMismatch($sformatf("sweep %0d register %0d", s, adr), rd,
						{16'h0000, stim[3 + 4 * s + w]});
				end
			end
			busRead(xadcMonPkg::REG_COUNT, rd);
			if (rd !== 32'(s + 1)) reportMismatch("REG_COUNT", rd, 32'(s + 1));
			curTest = 4;
			if (led[0] !== expAlarm) begin
				reportMismatch("led[0]", {31'h0, led[0]}, {31'h0, expAlarm});
			end
			busRead(xadcMonPkg::REG_STATUS, rd);
			if ({rd[2], rd[0]} !== {expAlarm, expSticky0}) begin
				reportMismatch("REG_STATUS bits 2,0", {30'h0, rd[2], rd[0]},
					{30'h0, expAlarm, expSticky0});
			end
			curTest = 5;
			if (rd[1] !== expSticky1) begin
				reportMismatch("REG_STATUS[1]", {31'h0, rd[1]}, {31'h0, expSticky1});
			end
			if (expSticky1 && !cleared) begin
				busWrite(xadcMonPkg::REG_STATUS, 32'h0000_0003);
				expSticky0 = 1'b0;
				expSticky1 = 1'b0;
				cleared = 1'b1;
				busRead(xadcMonPkg::REG_STATUS, rd);
				if (rd[2:0] !== {expAlarm, 2'b00}) begin
					reportMismatch("REG_STATUS", {29'h0, rd[2:0]},
						{29'h0, expAlarm, 2'b00});
				end
				if (!expAlarm) begin
					reportFailure("alarm was not active when the sticky bits were cleared");
				end
			end
		end
		curTest = 5;
		if (!cleared) reportFailure("no sweep in the stimulus set the overTemp flag");
		testErr[3] = testErr[3] + drpErr;
		drpSnap = drpErr;
		finishTest(3, "sweep order and results");
		finishTest(4, "alarm hysteresis");
		finishTest(5, "sticky status");

		// stop mid sweep
		curTest = 6;
		while (denCount <= 4 * nSweeps) @(posedge oscSysClk);
		busWrite(xadcMonPkg::REG_CTRL, {pollPeriod, 16'h0000});
		while (remain != 0) @(posedge oscSysClk);
		denSnap = denCount;
		repeat (4 * maxLatency + int'(pollPeriod) + 4) @(negedge oscSysClk);
		if (denCount != denSnap) reportFailure("den kept coming after enable was cleared");
		busRead(xadcMonPkg::REG_COUNT, rd);
		if (rd !== 32'(nSweeps)) reportMismatch("REG_COUNT", rd, 32'(nSweeps));
		testErr[6] = testErr[6] + drpErr - drpSnap;
		finishTest(6, "disable");

		errTotal = 0;
		failed = 0;
		for (int t = 1; t <= 6; t++) begin
			errTotal = errTotal + testErr[t];
			if (testErr[t] != 0) failed = failed + 1;
		end
		$display("summary: 6 tests, %0d failed, %0d errors", failed, errTotal);
		if (errTotal == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src/xadcMonitorTop.sv
/*
 * XADC monitor top: register block, DRP sequencer, threshold,
 * DRP port out to the XADC and status LEDs
 */
`timescale 1ns/1ns
`default_nettype none

module xadcMonitorTop #(
	// poll period after reset, in clock cycles
	parameter logic [15:0] defaultPeriod = 16'd100
) (
	input  logic               oscSysClk,
	input  logic               rstN,
	input  xadcMonPkg::wbReqT  wbReq,
	output xadcMonPkg::wbRspT  wbRsp,
	output xadcMonPkg::drpReqT drpReq,
	input  xadcMonPkg::drpRspT drpRsp,
	output logic [1:0]         led
);

	xadcMonPkg::monCfgT    cfg;
	xadcMonPkg::monResultT result;
	logic                  sweepDone;
	logic                  alarm;
	logic                  alarmRise;

	// ------------------------------
	// blocks
	// ------------------------------
	monitorRegs #(
		.defaultPeriod (defaultPeriod)
	) regs (
		.oscSysClk (oscSysClk),
		.rstN      (rstN),
		.wbReq     (wbReq),
		.wbRsp     (wbRsp),
		.cfg       (cfg),
		.result    (result),
		.sweepDone (sweepDone),
		.alarmRise (alarmRise),
		.alarm     (alarm)
	);

	// DRP goes straight out, the XADC sits outside
	drpSequencer seq (
		.oscSysClk (oscSysClk),
		.rstN      (rstN),
		.cfg       (cfg),
		.drpReq    (drpReq),
		.drpRsp    (drpRsp),
		.result    (result),
		.sweepDone (sweepDone)
	);

	tempThreshold thresh (
		.oscSysClk (oscSysClk),
		.rstN      (rstN),
		.cfg       (cfg),
		.result    (result),
		.sweepDone (sweepDone),
		.alarm     (alarm),
		.alarmRise (alarmRise)
	);

	// led 0 alarm, led 1 toggles per sweep via the count lsb
	assign led = {result.sweepCount[0], alarm};

endmodule

`default_nettype wire

//--- src/monitorRegs.sv
/*
 * Wishbone classic register block: control and thresholds,
 * sticky status, read-only sweep results
 */
`timescale 1ns/1ns
`default_nettype none

module monitorRegs #(
	parameter logic [15:0] defaultPeriod = 16'd100
) (
	input  logic                  oscSysClk,
	input  logic                  rstN,
	input  xadcMonPkg::wbReqT     wbReq,
	output xadcMonPkg::wbRspT     wbRsp,
	output xadcMonPkg::monCfgT    cfg,
	input  xadcMonPkg::monResultT result,
	input  logic                  sweepDone,
	input  logic                  alarmRise,
	input  logic                  alarm
);

	logic        ack;
	logic [31:0] datR;
	logic [31:0] rdData;
	logic        access;
	logic        wrEn;
	logic        stickyAlarm;
	logic        stickyOverTemp;
	logic        clrAlarm;
	logic        clrOverTemp;

	assign wbRsp = '{ack: ack, datR: datR};

	// a new request is one not yet acked
	assign access = wbReq.cyc & wbReq.stb & ~ack;
	assign wrEn   = access & wbReq.we;

	// write 1 to clear the sticky bits
	assign clrAlarm    = wrEn && wbReq.adr == xadcMonPkg::REG_STATUS && wbReq.datW[0];
	assign clrOverTemp = wrEn && wbReq.adr == xadcMonPkg::REG_STATUS && wbReq.datW[1];

	// ------------------------------
	// read mux
	// ------------------------------
	always_comb begin
		case (wbReq.adr)
			xadcMonPkg::REG_CTRL:   rdData = {cfg.pollPeriod, 15'h0000, cfg.enable};
			xadcMonPkg::REG_THRESH: rdData = {4'h0, cfg.tempHigh, 4'h0, cfg.tempLow};
			// bit 2 is the live alarm
			xadcMonPkg::REG_STATUS: rdData = {29'h0, alarm, stickyOverTemp, stickyAlarm};
			xadcMonPkg::REG_TEMP:   rdData = {16'h0000, result.temp};
			xadcMonPkg::REG_VCCINT: rdData = {16'h0000, result.vccInt};
			xadcMonPkg::REG_VCCAUX: rdData = {16'h0000, result.vccAux};
			xadcMonPkg::REG_FLAGS:  rdData = {16'h0000, result.flags};
			xadcMonPkg::REG_COUNT:  rdData = {16'h0000, result.sweepCount};
			// unmapped words read as zero
			default: rdData = 32'h0000_0000;
		endcase
	end

	// ------------------------------
	// bus handshake
	// ------------------------------
	// ack one cycle after the request with the read data
	always_ff @(posedge oscSysClk or negedge rstN) begin
		if (!rstN) begin
			ack  <= 1'b0;
			datR <= 32'h0000_0000;
		end else begin
			ack <= access;
			if (access) begin
				datR <= rdData;
			end
		end
	end

	// config registers take a write in the ack cycle
	always_ff @(posedge oscSysClk or negedge rstN) begin
		if (!rstN) begin
			cfg.enable     <= 1'b0;
			cfg.pollPeriod <= defaultPeriod;
			cfg.tempHigh   <= xadcMonPkg::TEMP_HIGH_RST;
			cfg.tempLow    <= xadcMonPkg::TEMP_LOW_RST;
		end else if (wrEn) begin
			case (wbReq.adr)
				xadcMonPkg::REG_CTRL: begin
					cfg.enable     <= wbReq.datW[0];
					cfg.pollPeriod <= wbReq.datW[31:16];
				end
				xadcMonPkg::REG_THRESH: begin
					cfg.tempLow  <= wbReq.datW[11:0];
					cfg.tempHigh <= wbReq.datW[27:16];
				end
				// status and result words are not written here
				default: ;
			endcase
		end
	end

	// ------------------------------
	// sticky status
	// ------------------------------
	// a new event wins over a clear in the same cycle
	always_ff @(posedge oscSysClk or negedge rstN) begin
		if (!rstN) begin
			stickyAlarm    <= 1'b0;
			stickyOverTemp <= 1'b0;
		end else begin
			stickyAlarm <= alarmRise | (stickyAlarm & ~clrAlarm);
			// overTemp of the XADC flags word is looked at once per sweep
			stickyOverTemp <= (sweepDone & result.flags.flag.overTemp)
				| (stickyOverTemp & ~clrOverTemp);
		end
	end

	// ack answers a request seen the cycle before
	ackAfterReq: assert property (@(posedge oscSysClk) disable iff (!rstN)
		ack |-> $past(wbReq.cyc && wbReq.stb));

endmodule

`default_nettype wire

//--- src/tempThreshold.sv
/*
 * over-temperature alarm with hysteresis between tempLow and tempHigh
 */
`timescale 1ns/1ns
`default_nettype none

module tempThreshold (
	input  logic                  oscSysClk,
	input  logic                  rstN,
	input  xadcMonPkg::monCfgT    cfg,
	input  xadcMonPkg::monResultT result,
	input  logic                  sweepDone,
	output logic                  alarm,
	output logic                  alarmRise
);

	logic [11:0] tempCode;
	logic        overHigh;
	logic        underLow;

	// temperature as the 12 bit measurement code
	assign tempCode = result.temp.meas.code;
	assign overHigh = tempCode > cfg.tempHigh;
	assign underLow = tempCode < cfg.tempLow;

	// ------------------------------
	// hysteresis
	// ------------------------------
	// result is already new in the sweepDone cycle
	always_ff @(posedge oscSysClk or negedge rstN) begin
		if (!rstN) begin
			alarm     <= 1'b0;
			alarmRise <= 1'b0;
		end else begin
			alarmRise <= 1'b0;
			if (sweepDone) begin
				if (overHigh) begin
					alarm <= 1'b1;
					// edge only when coming from the cleared state
					alarmRise <= ~alarm;
				end else if (underLow) begin
					alarm <= 1'b0;
				end
				// between the thresholds the alarm holds
			end
		end
	end

endmodule

`default_nettype wire

//--- src/drpSequencer.sv
/*
 * DRP read sequencer: sweeps temperature, VCCINT, VCCAUX and flags
 * with one read in flight, then waits the poll period
 */
`timescale 1ns/1ns
`default_nettype none

module drpSequencer (
	input  logic                  oscSysClk,
	input  logic                  rstN,
	input  xadcMonPkg::monCfgT    cfg,
	output xadcMonPkg::drpReqT    drpReq,
	input  xadcMonPkg::drpRspT    drpRsp,
	output xadcMonPkg::monResultT result,
	output logic                  sweepDone
);

	typedef enum logic [1:0] {
		sIdle,
		sRead,
		sGap
	} stateT;

	stateT       state;
	logic        den;
	logic [6:0]  daddr;
	logic [1:0]  idx;
	logic [15:0] periodCnt;
	// set by den, cleared by drdy
	logic        readPending;

	// staged words of the running sweep
	// the flags word goes straight from dout into result
	xadcMonPkg::drpWordU tempQ;
	xadcMonPkg::drpWordU vccIntQ;
	xadcMonPkg::drpWordU vccAuxQ;

	// sweep order is fixed
	function automatic logic [6:0] addrOf(input logic [1:0] sel);
		case (sel)
			2'd0: addrOf = xadcMonPkg::ADDR_TEMP;
			2'd1: addrOf = xadcMonPkg::ADDR_VCCINT;
			2'd2: addrOf = xadcMonPkg::ADDR_VCCAUX;
			default: addrOf = xadcMonPkg::ADDR_FLAG;
		endcase
	endfunction

	// read only, so dwe and di are tied off
	assign drpReq = '{den: den, dwe: 1'b0, daddr: daddr, di: 16'h0000};

	// ------------------------------
	// sweep FSM
	// ------------------------------
	always_ff @(posedge oscSysClk or negedge rstN) begin
		if (!rstN) begin
			state     <= sIdle;
			den       <= 1'b0;
			daddr     <= xadcMonPkg::ADDR_TEMP;
			idx       <= 2'd0;
			periodCnt <= 16'd0;
			sweepDone <= 1'b0;
			result    <= '0;
		end else begin
			// den and sweepDone are single cycle strobes
			den       <= 1'b0;
			sweepDone <= 1'b0;
			case (state)
				sIdle: begin
					// a sweep always starts over at the temperature register
					if (cfg.enable) begin
						idx   <= 2'd0;
						daddr <= addrOf(2'd0);
						den   <= 1'b1;
						state <= sRead;
					end
				end
				sRead: begin
					if (drpRsp.drdy) begin
						if (idx == 2'd3) begin
							// the last word commits the whole sweep at once
							result.temp       <= tempQ;
							result.vccInt     <= vccIntQ;
							result.vccAux     <= vccAuxQ;
							result.flags      <= drpRsp.dout;
							// bit 0 of the count doubles as the sweep LED
							result.sweepCount <= result.sweepCount + 16'd1;
							sweepDone         <= 1'b1;
							periodCnt         <= 16'd1;
							state             <= sGap;
						end else if (cfg.enable) begin
							idx   <= idx + 2'd1;
							daddr <= addrOf(idx + 2'd1);
							den   <= 1'b1;
						end else begin
							// when disabled mid sweep stop once this read is back
							state <= sIdle;
						end
					end
				end
				sGap: begin
					if (!cfg.enable) begin
						state <= sIdle;
					end else if (periodCnt >= cfg.pollPeriod) begin
						idx   <= 2'd0;
						daddr <= addrOf(2'd0);
						den   <= 1'b1;
						state <= sRead;
					end else begin
						periodCnt <= periodCnt + 16'd1;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	// dout lands in the staging word of the current index
	always_ff @(posedge oscSysClk) begin
		if (state == sRead && drpRsp.drdy) begin
			case (idx)
				2'd0: tempQ <= drpRsp.dout;
				2'd1: vccIntQ <= drpRsp.dout;
				2'd2: vccAuxQ <= drpRsp.dout;
				default: ;
			endcase
		end
	end

	always_ff @(posedge oscSysClk or negedge rstN) begin
		if (!rstN) begin
			readPending <= 1'b0;
		end else begin
			readPending <= (readPending & ~drpRsp.drdy) | den;
		end
	end

	// one outstanding read at most
	denWhilePending: assert property (@(posedge oscSysClk) disable iff (!rstN)
		den |-> !readPending);
	// the XADC only answers a read we issued
	drdyWithoutRead: assert property (@(posedge oscSysClk) disable iff (!rstN)
		drpRsp.drdy |-> readPending);

endmodule

`default_nettype wire

//--- src/xadcMonPkg.sv
/*
 * shared types for the XADC monitor: DRP and Wishbone bundles,
 * the DRP word union, result and configuration records, address constants
 */
`default_nettype none

package xadcMonPkg;

	// ------------------------------
	// DRP port
	// ------------------------------
	typedef struct packed {
		logic        den;
		logic        dwe;
		logic [6:0]  daddr;
		logic [15:0] di;
	} drpReqT;

	typedef struct packed {
		logic        drdy;
		logic [15:0] dout;
	} drpRspT;

	// measurement registers are left aligned, 12 bit code on top
	typedef struct packed {
		logic [11:0] code;
		logic [3:0]  unused;
	} drpMeasT;

	// flag register, only the low nibble is looked at
	typedef struct packed {
		logic [11:0] reserved;
		logic        overTemp;
		logic [2:0]  alarm;
	} drpFlagT;

	// one DRP word, read either as a measurement or as flags
	typedef union packed {
		drpMeasT meas;
		drpFlagT flag;
	} drpWordU;

	// ------------------------------
	// Wishbone classic
	// ------------------------------
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  adr;
		logic [31:0] datW;
	} wbReqT;

	typedef struct packed {
		logic        ack;
		logic [31:0] datR;
	} wbRspT;

	// results of the last complete sweep
	typedef struct packed {
		drpWordU     temp;
		drpWordU     vccInt;
		drpWordU     vccAux;
		drpWordU     flags;
		logic [15:0] sweepCount;
	} monResultT;

	typedef struct packed {
		logic        enable;
		logic [15:0] pollPeriod;
		logic [11:0] tempHigh;
		logic [11:0] tempLow;
	} monCfgT;

	// XADC status register addresses on the DRP
	localparam logic [6:0] ADDR_TEMP   = 7'h00;
	localparam logic [6:0] ADDR_VCCINT = 7'h01;
	localparam logic [6:0] ADDR_VCCAUX = 7'h02;
	localparam logic [6:0] ADDR_FLAG   = 7'h3F;

	// register map, word addresses
	localparam logic [3:0] REG_CTRL   = 4'd0;
	localparam logic [3:0] REG_THRESH = 4'd1;
	localparam logic [3:0] REG_STATUS = 4'd2;
	localparam logic [3:0] REG_TEMP   = 4'd3;
	localparam logic [3:0] REG_VCCINT = 4'd4;
	localparam logic [3:0] REG_VCCAUX = 4'd5;
	localparam logic [3:0] REG_FLAGS  = 4'd6;
	localparam logic [3:0] REG_COUNT  = 4'd7;

	// threshold reset values, alarm can never set until configured
	localparam logic [11:0] TEMP_HIGH_RST = 12'hFFF;
	localparam logic [11:0] TEMP_LOW_RST  = 12'h000;

endpackage

`default_nettype wire
